//--- rtl/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// instruction word fields
`define CTRL_OPCODE_W 6
`define CTRL_FUNCT_W 6

// control word fields wider than one bit and not held in an enum
`define CTRL_REGDEST_W 3 // 0 rt, 1 rd, 2 link reg
`define CTRL_RESULT_W 4 // result mux select

`endif

//--- rtl/ctrl_pkg.sv
`include "ctrl_macros.svh"

package ctrl_pkg;

	typedef enum logic [`CTRL_OPCODE_W-1:0] {
		opRtype = 6'd0,
		opLw = 6'd1,
		opSw = 6'd2,
		opAddi = 6'd3,
		opSubi = 6'd4,
		opLi = 6'd5,
		opLui = 6'd6,
		opBeq = 6'd7,
		opBnq = 6'd8,
		opIn = 6'd9,
		opOut = 6'd10,
		opJ = 6'd11,
		opJal = 6'd12,
		opJu = 6'd13,
		opJual = 6'd14,
		opPush = 6'd15,
		opPop = 6'd16,
		opSend = 6'd17,
		opRecv = 6'd18,
		opHalt = 6'd63
	} opcode_e;

	typedef enum logic [`CTRL_FUNCT_W-1:0] {
		fnSll = 6'd0,
		fnSrl = 6'd1,
		fnSra = 6'd2,
		fnCsl = 6'd3, // circular shifts
		fnCsr = 6'd4,
		fnAdd = 6'd5,
		fnSub = 6'd6,
		fnMult = 6'd7,
		fnDiv = 6'd8,
		fnInc = 6'd9,
		fnDec = 6'd10,
		fnMod = 6'd11,
		fnAnd = 6'd12,
		fnOr = 6'd13,
		fnNot = 6'd14,
		fnXor = 6'd15,
		fnMove = 6'd16,
		fnSlt = 6'd17,
		fnSgt = 6'd18,
		fnSet = 6'd19,
		fnJr = 6'd20,
		fnJalr = 6'd21
	} funct_e;

	typedef enum logic [1:0] {
		pcNext = 2'd0,
		pcHold = 2'd1, // refetch same instruction
		pcBranch = 2'd2,
		pcJump = 2'd3
	} pcDest_e;

	typedef enum logic [1:0] {
		jmpNone = 2'd0,
		jmpImm = 2'd1,
		jmpUpper = 2'd2,
		jmpReg = 2'd3
	} jumpOp_e;

	typedef enum logic [1:0] {
		stkNone = 2'd0,
		stkPush = 2'd1,
		stkPop = 2'd2
	} stackOp_e;

	typedef enum logic [1:0] {
		outNone = 2'd0,
		outIn = 2'd1,
		outOut = 2'd2
	} outCtrl_e;

	typedef enum logic [2:0] {
		waitNone = 3'd0,
		waitButtonIn = 3'd1,
		waitButtonOut = 3'd2,
		waitSend = 3'd3,
		waitRecv = 3'd4
	} waitSrc_e;

	typedef struct packed {
		logic buttonIn;
		logic buttonOut;
		logic switchSide; // picks extension side for in
		logic sendFlag;
		logic recvFlag;
	} ioFlags_t;

	typedef struct packed {
		logic [`CTRL_REGDEST_W-1:0] regDest;
		logic regWrite;
		logic extSide;
		logic twoComplement;
		logic regAlu; // immediate as alu operand b
		logic memWrite;
		logic memRead;
		jumpOp_e jumpOp;
		pcDest_e pcDest;
		outCtrl_e outputControl;
		stackOp_e stackOp;
		logic [`CTRL_RESULT_W-1:0] resultDest;
	} ctrlWord_t;

endpackage

//--- rtl/funct_decoder.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module funct_decoder
	import ctrl_pkg::*;
(
	input logic [`CTRL_FUNCT_W-1:0] funct,
	output ctrlWord_t rtypeWord
);

	always_comb begin
		rtypeWord = '0; // unknown funct is a no-op
		case (funct_e'(funct))
			fnSll, fnSrl, fnSra: begin
				rtypeWord.regWrite = 1'b1;
			end
			fnCsl, fnCsr: begin
				rtypeWord.regWrite = 1'b1;
			end
			fnInc, fnDec: begin
				rtypeWord.regWrite = 1'b1; // single source, writes rt
			end
			fnNot, fnMove: begin
				rtypeWord.regWrite = 1'b1;
			end
			fnAdd, fnSub: begin
				rtypeWord.regDest = 3'd1;
				rtypeWord.regWrite = 1'b1;
			end
			fnMult, fnDiv, fnMod: begin
				rtypeWord.regDest = 3'd1;
				rtypeWord.regWrite = 1'b1;
			end
			fnAnd, fnOr, fnXor: begin
				rtypeWord.regDest = 3'd1;
				rtypeWord.regWrite = 1'b1;
			end
			fnSlt, fnSgt, fnSet: begin
				rtypeWord.regDest = 3'd1; // compare result to rd
				rtypeWord.regWrite = 1'b1;
			end
			fnJr: begin
				rtypeWord.jumpOp = jmpReg;
				rtypeWord.pcDest = pcJump;
			end
			fnJalr: begin
				rtypeWord.regDest = 3'd2; // link register
				rtypeWord.regWrite = 1'b1;
				rtypeWord.jumpOp = jmpReg;
				rtypeWord.pcDest = pcJump;
				rtypeWord.resultDest = 4'd4; // return address
			end
			default: begin
				rtypeWord = '0;
			end
		endcase
	end

endmodule

//--- rtl/opcode_decoder.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module opcode_decoder
	import ctrl_pkg::*;
(
	input logic [`CTRL_OPCODE_W-1:0] opcode,
	input ctrlWord_t rtypeWord,
	output ctrlWord_t baseWord,
	output waitSrc_e waitSrc
);

	always_comb begin
		baseWord = '0;
		waitSrc = waitNone;
		case (opcode_e'(opcode))
			opRtype: begin
				baseWord = rtypeWord;
			end
			opLw: begin
				baseWord.regWrite = 1'b1;
				baseWord.regAlu = 1'b1;
				baseWord.memRead = 1'b1;
				baseWord.resultDest = 4'd2; // memory data
			end
			opSw: begin
				baseWord.regAlu = 1'b1;
				baseWord.memWrite = 1'b1;
			end
			opAddi, opSubi: begin
				baseWord.regWrite = 1'b1;
				baseWord.twoComplement = 1'b1;
				baseWord.regAlu = 1'b1;
			end
			opLi: begin
				baseWord.regWrite = 1'b1;
				baseWord.twoComplement = 1'b1;
				baseWord.regAlu = 1'b1;
				baseWord.resultDest = 4'd1; // extended immediate
			end
			opLui: begin
				baseWord.regWrite = 1'b1;
				baseWord.extSide = 1'b1; // upper half
				baseWord.twoComplement = 1'b1;
				baseWord.regAlu = 1'b1;
				baseWord.resultDest = 4'd1;
			end
			opBeq, opBnq: begin
				baseWord.twoComplement = 1'b1;
				baseWord.pcDest = pcBranch;
			end
			opIn: begin
				baseWord.regWrite = 1'b1;
				baseWord.twoComplement = 1'b1;
				baseWord.outputControl = outIn;
				baseWord.resultDest = 4'd3; // switch input
				waitSrc = waitButtonIn;
			end
			opOut: begin
				baseWord.outputControl = outOut;
				waitSrc = waitButtonOut;
			end
			opJ: begin
				baseWord.jumpOp = jmpImm;
				baseWord.pcDest = pcJump;
			end
			opJu: begin
				baseWord.jumpOp = jmpUpper;
				baseWord.pcDest = pcJump;
			end
			opJal: begin
				baseWord.regDest = 3'd2;
				baseWord.regWrite = 1'b1;
				baseWord.jumpOp = jmpImm;
				baseWord.pcDest = pcJump;
				baseWord.resultDest = 4'd4;
			end
			opJual: begin
				baseWord.regDest = 3'd2;
				baseWord.regWrite = 1'b1;
				baseWord.jumpOp = jmpUpper;
				baseWord.pcDest = pcJump;
				baseWord.resultDest = 4'd4;
			end
			opPush: begin
				baseWord.stackOp = stkPush;
			end
			opPop: begin
				baseWord.regWrite = 1'b1;
				baseWord.stackOp = stkPop;
				baseWord.resultDest = 4'd5; // stack top
			end
			opSend: begin
				waitSrc = waitSend;
			end
			opRecv: begin
				baseWord.resultDest = 4'd8; // serial rx data
				waitSrc = waitRecv;
			end
			opHalt: begin
				baseWord.pcDest = pcHold;
			end
			default: begin
				// anything unknown, including the dropped OS and disk ops, halts
				baseWord.pcDest = pcHold;
			end
		endcase
	end

endmodule

//--- rtl/io_wait_gate.sv
`timescale 1ns/1ps

module io_wait_gate
	import ctrl_pkg::*;
(
	input ctrlWord_t baseWord,
	input waitSrc_e waitSrc,
	input ioFlags_t ioFlags,
	output ctrlWord_t finalWord
);

	logic flagReady;

	always_comb begin
		case (waitSrc)
			waitButtonIn: flagReady = ioFlags.buttonIn;
			waitButtonOut: flagReady = ioFlags.buttonOut;
			waitSend: flagReady = ioFlags.sendFlag;
			waitRecv: flagReady = ioFlags.recvFlag;
			default: flagReady = 1'b1;
		endcase
	end

	always_comb begin
		finalWord = baseWord;
		if (waitSrc != waitNone) begin
			if (flagReady) begin
				finalWord.pcDest = pcNext;
			end else begin
				finalWord.pcDest = pcHold; // spin until flag is set
			end
		end
		if (waitSrc == waitRecv) begin
			finalWord.regWrite = ioFlags.recvFlag; // write only once data is there
		end
		if (waitSrc == waitButtonIn) begin
			finalWord.extSide = ioFlags.switchSide;
		end
	end

endmodule

//--- rtl/control_unit.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module control_unit
	import ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic instValid,
	input logic [`CTRL_OPCODE_W-1:0] opcode,
	input logic [`CTRL_FUNCT_W-1:0] funct,
	input ioFlags_t ioFlags,
	output logic ctrlValid,
	output ctrlWord_t ctrl
);

	ctrlWord_t rtypeWord;
	ctrlWord_t baseWord;
	ctrlWord_t finalWord;
	waitSrc_e waitSrc;

	funct_decoder u_funct_decoder (
		.funct(funct),
		.rtypeWord(rtypeWord)
	);

	opcode_decoder u_opcode_decoder (
		.opcode(opcode),
		.rtypeWord(rtypeWord),
		.baseWord(baseWord),
		.waitSrc(waitSrc)
	);

	io_wait_gate u_io_wait_gate (
		.baseWord(baseWord),
		.waitSrc(waitSrc),
		.ioFlags(ioFlags),
		.finalWord(finalWord)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlValid <= 1'b0;
			ctrl <= '0;
		end else begin
			ctrlValid <= instValid; // one cycle behind the strobe
			if (instValid) begin
				ctrl <= finalWord;
			end
		end
	end

endmodule

//--- dv/control_unit_chk.sv
`timescale 1ns/1ps

module control_unit_chk
	import ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic instValid,
	input logic ctrlValid,
	input ctrlWord_t ctrl
);

	int failCount = 0;

	validAfterStrobe: assert property (@(posedge clk) disable iff (rst)
		instValid |=> ctrlValid)
		else begin
			$error("ctrlValid missing one cycle after a strobe");
			failCount++;
		end

	noValidWithoutStrobe: assert property (@(posedge clk) disable iff (rst)
		!instValid |=> !ctrlValid)
		else begin
			$error("ctrlValid high without a strobe one cycle earlier");
			failCount++;
		end

	idleAfterReset: assert property (@(posedge clk) rst |=> !ctrlValid)
		else begin
			$error("ctrlValid high in the cycle after reset");
			failCount++;
		end

	noMemConflict: assert property (@(posedge clk) disable iff (rst)
		!(ctrl.memRead && ctrl.memWrite))
		else begin
			$error("memRead and memWrite both high");
			failCount++;
		end

	stackOpLegal: assert property (@(posedge clk) disable iff (rst)
		ctrl.stackOp != 2'd3)
		else begin
			$error("stackOp holds unused encoding 3");
			failCount++;
		end

endmodule

//--- dv/control_unit_monitor.sv
`timescale 1ns/1ps

module control_unit_monitor
	import ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic ctrlValid,
	input ctrlWord_t ctrl
);

	ctrlWord_t expQueue[$];
	string nameQueue[$];
	int passCount = 0;
	int errorCount = 0;
	bit resetSeen = 1'b0;

	task automatic pushExpected(input ctrlWord_t word, input string name);
		expQueue.push_back(word);
		nameQueue.push_back(name);
	endtask

	function automatic int pendingCount();
		return expQueue.size();
	endfunction

	function automatic int compareField(input string field, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %0h expected %0h", $time, field, got, exp);
			return 1;
		end
		return 0;
	endfunction

	task automatic checkWord(input ctrlWord_t exp, input string name);
		int bad;
		bad = 0;
		bad += compareField("ctrl.regDest", ctrl.regDest, exp.regDest);
		bad += compareField("ctrl.regWrite", ctrl.regWrite, exp.regWrite);
		bad += compareField("ctrl.extSide", ctrl.extSide, exp.extSide);
		bad += compareField("ctrl.twoComplement", ctrl.twoComplement, exp.twoComplement);
		bad += compareField("ctrl.regAlu", ctrl.regAlu, exp.regAlu);
		bad += compareField("ctrl.memWrite", ctrl.memWrite, exp.memWrite);
		bad += compareField("ctrl.memRead", ctrl.memRead, exp.memRead);
		bad += compareField("ctrl.jumpOp", ctrl.jumpOp, exp.jumpOp);
		bad += compareField("ctrl.pcDest", ctrl.pcDest, exp.pcDest);
		bad += compareField("ctrl.outputControl", ctrl.outputControl, exp.outputControl);
		bad += compareField("ctrl.stackOp", ctrl.stackOp, exp.stackOp);
		bad += compareField("ctrl.resultDest", ctrl.resultDest, exp.resultDest);
		if (bad == 0) begin
			passCount++;
			$display("pass: %s", name);
		end else begin
			errorCount++;
			$display("fail: %s, %0d field(s) wrong", name, bad);
		end
	endtask

	// outputs settle after the rising edge, so look at them mid-cycle
	always @(negedge clk) begin
		ctrlWord_t exp;
		string name;
		int bad;
		if (!rst && !resetSeen) begin
			resetSeen = 1'b1;
			bad = compareField("ctrlValid", ctrlValid, 0);
			bad += compareField("ctrl", ctrl, 0);
			if (bad == 0) begin
				passCount++;
				$display("pass: state after reset");
			end else begin
				errorCount++;
				$display("fail: state after reset");
			end
		end
		if (!rst && ctrlValid === 1'b1) begin
			if (expQueue.size() == 0) begin
				errorCount++;
				$display("ERROR at %0t ns: ctrlValid went high with no result expected", $time);
			end else begin
				exp = expQueue.pop_front();
				name = nameQueue.pop_front();
				checkWord(exp, name);
			end
		end
	end

	task automatic finalReport();
		if (expQueue.size() != 0) begin
			errorCount++;
			$display("ERROR: %0d expected results never came out of the DUT", expQueue.size());
		end
		$display("tests passed: %0d, tests failed: %0d", passCount, errorCount);
	endtask

endmodule

//--- dv/control_unit_tb.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module control_unit_tb
	import ctrl_pkg::*;
();

	localparam int RESET_CYCLES = 8;

	typedef struct packed {
		logic [`CTRL_OPCODE_W-1:0] opcode;
		logic [`CTRL_FUNCT_W-1:0] funct;
		ioFlags_t flags;
		ctrlWord_t expWord;
	} stimRow_t;

	logic clk;
	logic rst;
	logic instValid;
	logic [`CTRL_OPCODE_W-1:0] opcode;
	logic [`CTRL_FUNCT_W-1:0] funct;
	ioFlags_t ioFlags;
	logic ctrlValid;
	ctrlWord_t ctrl;

	stimRow_t rows[$];
	string rowNames[$];
	int cycleCount = 0;
	int cycleLimit = 0;

	control_unit u_control_unit (
		.clk(clk),
		.rst(rst),
		.instValid(instValid),
		.opcode(opcode),
		.funct(funct),
		.ioFlags(ioFlags),
		.ctrlValid(ctrlValid),
		.ctrl(ctrl)
	);

	control_unit_monitor u_monitor (
		.clk(clk),
		.rst(rst),
		.ctrlValid(ctrlValid),
		.ctrl(ctrl)
	);

	bind control_unit control_unit_chk u_control_unit_chk (
		.clk(clk),
		.rst(rst),
		.instValid(instValid),
		.ctrlValid(ctrlValid),
		.ctrl(ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reference model of the decode rules
	function automatic ctrlWord_t expectWord(input logic [5:0] op, input logic [5:0] fn,
		input ioFlags_t f);
		ctrlWord_t w;
		logic waits;
		logic ready;
		w = '0;
		waits = 1'b0;
		ready = 1'b0;
		case (op)
			opRtype: begin
				if (fn <= 6'd19) w.regWrite = 1'b1;
				case (fn)
					fnAdd, fnSub, fnMult, fnDiv, fnMod, fnAnd,
					fnOr, fnXor, fnSlt, fnSgt, fnSet: w.regDest = 3'd1;
					default: w.regDest = 3'd0;
				endcase
				if (fn == fnJr || fn == fnJalr) begin
					w.jumpOp = jmpReg;
					w.pcDest = pcJump;
				end
				if (fn == fnJalr) begin
					w.regDest = 3'd2;
					w.regWrite = 1'b1;
					w.resultDest = 4'd4;
				end
			end
			opLw: begin
				w.regWrite = 1'b1;
				w.regAlu = 1'b1;
				w.memRead = 1'b1;
				w.resultDest = 4'd2;
			end
			opSw: begin
				w.regAlu = 1'b1;
				w.memWrite = 1'b1;
			end
			opAddi, opSubi, opLi, opLui: begin
				w.regWrite = 1'b1;
				w.twoComplement = 1'b1;
				w.regAlu = 1'b1;
				if (op != opAddi && op != opSubi) w.resultDest = 4'd1;
				w.extSide = (op == opLui);
			end
			opBeq, opBnq: begin
				w.twoComplement = 1'b1;
				w.pcDest = pcBranch;
			end
			opJ, opJu, opJal, opJual: begin
				w.jumpOp = (op == opJ || op == opJal) ? jmpImm : jmpUpper;
				w.pcDest = pcJump;
				if (op == opJal || op == opJual) begin
					w.regDest = 3'd2;
					w.regWrite = 1'b1;
					w.resultDest = 4'd4;
				end
			end
			opPush: w.stackOp = stkPush;
			opPop: begin
				w.regWrite = 1'b1;
				w.stackOp = stkPop;
				w.resultDest = 4'd5;
			end
			opIn: begin
				w.regWrite = 1'b1;
				w.twoComplement = 1'b1;
				w.outputControl = outIn;
				w.resultDest = 4'd3;
				w.extSide = f.switchSide;
				waits = 1'b1;
				ready = f.buttonIn;
			end
			opOut: begin
				w.outputControl = outOut;
				waits = 1'b1;
				ready = f.buttonOut;
			end
			opSend: begin
				waits = 1'b1;
				ready = f.sendFlag;
			end
			opRecv: begin
				w.resultDest = 4'd8;
				w.regWrite = f.recvFlag;
				waits = 1'b1;
				ready = f.recvFlag;
			end
			default: w.pcDest = pcHold; // halt, dropped and unused opcodes
		endcase
		if (waits) w.pcDest = ready ? pcNext : pcHold;
		return w;
	endfunction

	task automatic addRow(input logic [5:0] op, input logic [5:0] fn, input ioFlags_t flags,
		input string name);
		stimRow_t row;
		row.opcode = op;
		row.funct = fn;
		row.flags = flags;
		row.expWord = expectWord(op, fn, flags);
		rows.push_back(row);
		rowNames.push_back(name);
	endtask

	task automatic buildTable();
		funct_e fn;
		for (int f = 0; f <= 21; f++) begin
			fn = funct_e'(f);
			addRow(opRtype, fn, 5'b0, fn.name());
		end
		addRow(opRtype, 6'd45, 5'b0, "unknown funct");
		addRow(opLw, 6'd0, 5'b0, "lw");
		addRow(opSw, 6'd0, 5'b0, "sw");
		addRow(opAddi, 6'd0, 5'b0, "addi");
		addRow(opSubi, 6'd0, 5'b0, "subi");
		addRow(opLi, 6'd0, 5'b0, "li");
		addRow(opLui, 6'd0, 5'b0, "lui");
		addRow(opBeq, 6'd0, 5'b0, "beq");
		addRow(opBnq, 6'd0, 5'b0, "bnq");
		addRow(opJ, 6'd0, 5'b0, "j");
		addRow(opJal, 6'd0, 5'b0, "jal");
		addRow(opJu, 6'd0, 5'b0, "ju");
		addRow(opJual, 6'd0, 5'b0, "jual");
		addRow(opPush, 6'd0, 5'b0, "push");
		addRow(opPop, 6'd0, 5'b0, "pop");
		// flags are buttonIn buttonOut switchSide sendFlag recvFlag
		addRow(opIn, 6'd0, 5'b00100, "in waiting");
		addRow(opIn, 6'd0, 5'b10000, "in ready");
		addRow(opOut, 6'd0, 5'b10111, "out waiting");
		addRow(opOut, 6'd0, 5'b01000, "out ready");
		addRow(opSend, 6'd0, 5'b00000, "send waiting");
		addRow(opSend, 6'd0, 5'b00010, "send ready");
		addRow(opRecv, 6'd0, 5'b11110, "recv waiting");
		addRow(opRecv, 6'd0, 5'b00001, "recv ready");
		addRow(opHalt, 6'd0, 5'b0, "halt");
		addRow(6'd30, 6'd0, 5'b0, "dropped os opcode");
		addRow(6'd50, 6'd0, 5'b0, "unused opcode");
	endtask

	task automatic driveRow(input stimRow_t row);
		instValid <= 1'b1;
		opcode <= row.opcode;
		funct <= row.funct;
		ioFlags <= row.flags;
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			u_monitor.finalReport();
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		int seed;
		int rnd;
		int assertFails;
		stimRow_t row;
		seed = 32'hef7acb79;
		rst = 1'b1;
		instValid = 1'b0;
		opcode = '0;
		funct = '0;
		ioFlags = '0;
		buildTable();
		cycleLimit = RESET_CYCLES + 3 * rows.size() + 20;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		foreach (rows[i]) begin // back to back strobes
			@(posedge clk);
			driveRow(rows[i]);
			u_monitor.pushExpected(rows[i].expWord, rowNames[i]);
		end
		@(posedge clk);
		instValid <= 1'b0;
		foreach (rows[i]) begin // random flags with an idle cycle between
			rnd = $random(seed);
			row = rows[i];
			row.flags = rnd[4:0];
			row.expWord = expectWord(row.opcode, row.funct, row.flags);
			@(posedge clk);
			driveRow(row);
			u_monitor.pushExpected(row.expWord, {rowNames[i], " random flags"});
			@(posedge clk);
			instValid <= 1'b0;
		end
		while (u_monitor.pendingCount() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
		u_monitor.finalReport();
		assertFails = u_control_unit.u_control_unit_chk.failCount;
		if (u_monitor.errorCount == 0 && assertFails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/funct_decoder.sv
rtl/opcode_decoder.sv
rtl/io_wait_gate.sv
rtl/control_unit.sv
dv/control_unit_chk.sv
dv/control_unit_monitor.sv
dv/control_unit_tb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ctrl_pkg.sv
      - rtl/funct_decoder.sv
      - rtl/opcode_decoder.sv
      - rtl/io_wait_gate.sv
      - rtl/control_unit.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/control_unit_chk.sv
      - dv/control_unit_monitor.sv
      - dv/control_unit_tb.sv
